// File: list.f
+incdir+include
source/audio_types_pkg.sv
source/control_types_pkg.sv
source/button_press_unit.sv
source/mode_selector.sv
source/song_sequencer.sv
source/tone_generator.sv
source/i2s_transmitter.sv
source/music_player_top.sv
testbench/music_player_asserts.sv
testbench/music_player_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the music player simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
        --top-module music_player_tb -o music_player_sim; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/music_player_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: testbench/music_player_tb.sv
`default_nettype none

module music_player_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = 512;             // 64 bclk of 8 cycles
    localparam int TOTAL_FRAMES = 3 + 100 + 60 + 6;
    localparam int PRESS_CYCLES = 11 * 100;
    localparam int LIMIT = (TOTAL_FRAMES * FRAME_CYCLES + PRESS_CYCLES) * 6 / 5;

    logic       clk_100;
    logic       reset;
    logic [1:0] btn;   // Control on bit 1 and action on bit 0
    logic       bclk;
    logic       wclk;
    logic       dout;
    logic [3:0] leds;
    logic [2:0] leds_rgb_0;
    logic [8:0] div_cnt;
    int         cycles;
    int         seed;

    music_player_top #(.BPU_WIDTH(2), .BEAT_COUNT(6)) DUT (
        .clk_100(clk_100), .reset(reset), .btn(btn), .bclk(bclk), .wclk(wclk),
        .dout(dout), .leds(leds), .leds_rgb_0(leds_rgb_0)
    );

    always #2 clk_100 = ~clk_100;

    // Codec clocks with both falls aligned at frame start
    always @(posedge clk_100) begin
        if (reset) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            bclk    <= div_cnt[2];
            wclk    <= div_cnt[8];
        end
    end

    always @(posedge clk_100) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // Checker flag sampled away from the active edge
    always @(negedge clk_100) begin
        if (DUT.chk.failed) begin
            $display("mismatch at time %0t: %s", $time, DUT.chk.what);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    end

    task automatic wait_frames(input int n);
        repeat (n) @(negedge wclk);
    endtask

    // Clean press of random length and spacing
    task automatic press_button(input int b);
        int hold;
        int gap;
        hold = 8 + ({$random(seed)} % 13);
        gap  = 20 + ({$random(seed)} % 16);
        repeat (gap) @(posedge clk_100);
        btn[b] <= 1'b1;
        repeat (hold) @(posedge clk_100);
        btn[b] <= 1'b0;
        repeat (gap) @(posedge clk_100);
    endtask

    initial begin
        seed    = 32'h8f36712a;
        clk_100 = 1'b0;
        reset   = 1'b1;
        btn     = 2'b00;
        bclk    = 1'b0;
        wclk    = 1'b0;
        cycles  = 0;
        repeat (8) @(posedge clk_100);
        reset <= 1'b0;

        wait_frames(3);      // Idle with silent output
        press_button(0);     // Play
        wait_frames(100);    // Two full songs
        press_button(1);     // NEXT
        press_button(0);
        wait_frames(10);
        press_button(0);
        wait_frames(10);
        press_button(1);     // REWIND
        press_button(0);
        wait_frames(10);
        press_button(1);     // FFWD
        press_button(0);
        wait_frames(10);
        press_button(0);
        wait_frames(10);
        press_button(1);     // Back to PLAY
        press_button(0);     // Pause
        wait_frames(10);
        press_button(1);
        wait_frames(6);

        if (DUT.chk.failed) begin
            $display("Something failed");
            $fatal(1, "check failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/music_player_asserts.sv
`default_nettype none

`include "music_macros.svh"

module music_player_asserts
    import audio_types_pkg::*;
    import control_types_pkg::*;
#(
    parameter int BEATS = 6
) (
    input logic        clk_100,
    input logic        reset,
    input logic [1:0]  btn,
    input logic        bclk,
    input logic        wclk,
    input logic        dout,
    input logic [3:0]  leds,
    input logic [2:0]  leds_rgb_0,
    input player_cmd_t cmd,
    input logic        new_frame
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam sample_t AMP = `AMPLITUDE;
    // Melody copy for steps 0 to 7
    localparam note_t SONG [8] = '{4'd3, 4'd5, 4'd1, 4'd7, 4'd2, 4'd6, 4'd4, 4'd8};

    logic        failed = 1'b0;  // Read by the testbench
    string       what = "";

    // Button level models
    logic [1:0]  btn_q;
    logic [1:0]  btn_rise;
    logic        any_rise;
    logic [1:0]  mode_q;
    logic        play_q;
    logic [7:0]  ctl_presses, act_presses, mode_changes, play_changes, toggles_exp;

    // Song and tone model
    logic        m_play;
    step_t       m_step;
    int          m_beat;
    note_t       m_note, m_note_q;
    note_t       m_cnt;
    logic        m_pos;             // Level high
    sample_t     m_sample;
    logic        m_ns;              // Sample ready strobe
    codec_word_t exp_hold, exp_shift;

    // Deserializer
    logic [2:0]  bq, wq;
    logic        brise, wfall;
    int          idx;
    logic [23:0] rx;

    assign btn_rise = btn & ~btn_q;
    assign any_rise = |btn_rise;
    assign brise    = ~bq[2] & bq[1];   // Same lag as the DUT synchronizer
    assign wfall    = wq[2] & ~wq[1];

    always_ff @(posedge clk_100) begin
        if (reset) begin
            btn_q <= '0;
            mode_q <= '0;
            play_q <= 1'b0;
            ctl_presses <= '0;
            act_presses <= '0;
            mode_changes <= '0;
            play_changes <= '0;
            toggles_exp <= '0;
        end else begin
            btn_q  <= btn;
            mode_q <= leds_rgb_0[2:1];
            play_q <= leds_rgb_0[0];
            if (btn_rise[1]) ctl_presses <= ctl_presses + 1'b1;
            if (btn_rise[0]) act_presses <= act_presses + 1'b1;
            if (btn_rise[0] && leds_rgb_0[2:1] == 2'd0)
                toggles_exp <= toggles_exp + 1'b1;  // Action in PLAY mode
            if (leds_rgb_0[2:1] != mode_q) mode_changes <= mode_changes + 1'b1;
            if (leds_rgb_0[0] != play_q) play_changes <= play_changes + 1'b1;
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            m_play <= 1'b0;
            m_step <= '0;
            m_beat <= 0;
            m_note <= '0;
            m_note_q <= '0;
            m_cnt <= '0;
            m_pos <= 1'b1;
            m_sample <= '0;
            m_ns <= 1'b0;
            exp_hold <= '0;
        end else begin
            if (cmd.toggle_play) m_play <= ~m_play;
            if (cmd.step_rewind) begin
                m_step <= '0;
                m_beat <= 0;
            end else if (cmd.step_ffwd) begin
                m_step <= m_step + 3'd2;  // Wraps at 8
                m_beat <= 0;
            end else if (cmd.step_next) begin
                m_step <= m_step + 3'd1;
                m_beat <= 0;
            end else if (m_play && new_frame) begin
                if (m_beat == BEATS - 1) begin
                    m_beat <= 0;
                    m_step <= m_step + 3'd1;
                end else begin
                    m_beat <= m_beat + 1;
                end
            end
            m_note   <= SONG[m_step];
            m_note_q <= m_note;
            if (!m_play) begin
                m_cnt <= '0;
                m_pos <= 1'b1;
                m_sample <= '0;  // Silence while paused
            end else if (m_note != m_note_q) begin
                m_cnt <= '0;     // Fresh positive half period
                m_pos <= 1'b1;
            end else if (new_frame) begin
                m_sample <= m_pos ? AMP : -AMP;
                if (m_cnt == m_note) begin
                    m_cnt <= '0;
                    m_pos <= ~m_pos;
                end else begin
                    m_cnt <= m_cnt + 1'b1;
                end
            end
            m_ns <= new_frame;
            if (m_ns) exp_hold <= {m_sample, 8'h00};
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            bq <= '0;
            wq <= '0;
            idx <= 100;  // Idle until the first frame
            rx <= '0;
            exp_shift <= '0;
        end else begin
            bq <= {bq[1:0], bclk};
            wq <= {wq[1:0], wclk};
            if (wfall) begin
                idx <= -1;             // First rise still shows the old bit
                exp_shift <= exp_hold;
            end else if (brise) begin
                if (idx >= 0 && idx < 24) rx <= {rx[22:0], dout};
                if (idx < 100) idx <= idx + 1;
            end
        end
    end

    a_mode_step: assert property (@(posedge clk_100) disable iff (reset)
        (leds_rgb_0[2:1] != mode_q) |-> (leds_rgb_0[2:1] == mode_q + 2'd1))
        else begin
            what   = "mode index did not step by one";
            failed = 1'b1;
            $error("mode skipped");
        end

    a_mode_count: assert property (@(posedge clk_100) disable iff (reset)
        any_rise |-> (mode_changes == ctl_presses && leds_rgb_0[2:1] == ctl_presses[1:0]))
        else begin
            what   = "mode changes differ from presses";
            failed = 1'b1;
            $error("mode count");
        end

    a_play_count: assert property (@(posedge clk_100) disable iff (reset)
        any_rise |-> (play_changes == toggles_exp))
        else begin
            what   = "play toggles differ from presses";
            failed = 1'b1;
            $error("play count");
        end

    a_leds: assert property (@(posedge clk_100) disable iff (reset)
        leds == m_sample[15:12])
        else begin
            what   = "LED bits differ from the sample model";
            failed = 1'b1;
            $error("leds");
        end

    a_idle: assert property (@(posedge clk_100) disable iff (reset)
        (ctl_presses == 0 && act_presses == 0) |-> (leds_rgb_0 == 3'b000 && !dout))
        else begin
            what   = "activity before any press";
            failed = 1'b1;
            $error("idle");
        end

    a_word: assert property (@(posedge clk_100) disable iff (reset)
        (brise && idx == 23) |-> ({rx[22:0], dout} == exp_shift))
        else begin
            what   = "I2S word differs from model";
            failed = 1'b1;
            $error("word");
        end

endmodule

bind music_player_top music_player_asserts #(.BEATS(BEAT_COUNT)) chk (
    .clk_100(clk_100), .reset(reset), .btn(btn), .bclk(bclk), .wclk(wclk),
    .dout(dout), .leds(leds), .leds_rgb_0(leds_rgb_0), .cmd(cmd), .new_frame(new_frame)
);

`default_nettype wire

// File: source/music_player_top.sv
`default_nettype none

`include "music_macros.svh"

module music_player_top
    import audio_types_pkg::*;
    import control_types_pkg::*;
#(
    parameter int BPU_WIDTH  = `BPU_WIDTH,
    parameter int BEAT_COUNT = `BEAT_COUNT
) (
    input  logic       clk_100,
    input  logic       reset,
    input  logic [1:0] btn,         // Bit 1 control, bit 0 action
    input  logic       bclk,        // Codec bit clock
    input  logic       wclk,        // Codec word clock
    output logic       dout,
    output logic [3:0] leds,
    output logic [2:0] leds_rgb_0
);

    logic         control_press;
    logic         action_press;
    player_cmd_t  cmd;
    player_mode_t mode;
    note_t        note;
    logic         playing;
    sample_t      sample;
    logic         new_sample;
    logic         new_frame;

    // Button front ends
    button_press_unit #(.WIDTH(BPU_WIDTH)) control_bpu (
        .clk_100(clk_100), .reset(reset), .in(btn[1]), .out(control_press)
    );
    button_press_unit #(.WIDTH(BPU_WIDTH)) action_bpu (
        .clk_100(clk_100), .reset(reset), .in(btn[0]), .out(action_press)
    );

    mode_selector u_mode_selector (
        .clk_100(clk_100), .reset(reset), .control_press(control_press),
        .action_press(action_press), .cmd(cmd), .mode(mode)
    );

    song_sequencer #(.BEAT_COUNT(BEAT_COUNT)) u_song_sequencer (
        .clk_100(clk_100), .reset(reset), .cmd(cmd), .new_frame(new_frame),
        .note(note), .playing(playing)
    );

    tone_generator u_tone_generator (
        .clk_100(clk_100), .reset(reset), .new_frame(new_frame), .playing(playing),
        .note(note), .sample(sample), .new_sample(new_sample)
    );

    i2s_transmitter u_i2s_transmitter (
        .clk_100(clk_100), .reset(reset), .bclk(bclk), .wclk(wclk), .sample(sample),
        .new_sample(new_sample), .new_frame(new_frame), .dout(dout)
    );

    assign leds       = sample[15:12];            // Top bits of the waveform
    assign leds_rgb_0 = {2'(mode), playing};      // Mode index and play flag

endmodule

`default_nettype wire

// File: source/i2s_transmitter.sv
`default_nettype none

`include "music_macros.svh"

module i2s_transmitter
    import audio_types_pkg::*;
(
    input  logic    clk_100,
    input  logic    reset,
    input  logic    bclk,
    input  logic    wclk,
    input  sample_t sample,
    input  logic    new_sample,
    output logic    new_frame,
    output logic    dout
);

    localparam int CNT_W = $clog2(`CODEC_WIDTH + 1);

    logic [2:0]  bclk_q;     // Two sync flops plus one for edge detect
    logic [2:0]  wclk_q;
    logic        bclk_fall;
    logic        wclk_fall;
    logic        wclk_rise;
    codec_word_t hold_word;  // Next word to send
    codec_word_t shift_reg;
    logic [CNT_W-1:0] bits_left;

    assign bclk_fall = bclk_q[2] & ~bclk_q[1];
    assign wclk_fall = wclk_q[2] & ~wclk_q[1];  // Left channel starts
    assign wclk_rise = ~wclk_q[2] & wclk_q[1];  // Right channel starts

    always_ff @(posedge clk_100) begin
        if (reset) begin
            bclk_q    <= '0;
            wclk_q    <= '0;
            new_frame <= 1'b0;
            hold_word <= '0;
            shift_reg <= '0;
            bits_left <= '0;
            dout      <= 1'b0;
        end else begin
            bclk_q    <= {bclk_q[1:0], bclk};
            wclk_q    <= {wclk_q[1:0], wclk};
            new_frame <= wclk_fall;  // Paces the whole player

            if (new_sample)
                hold_word <= to_codec_word(sample);

            if (wclk_fall) begin
                shift_reg <= hold_word;  // Word from the previous frame
                bits_left <= CNT_W'(`CODEC_WIDTH);
            end else if (wclk_rise) begin
                bits_left <= '0;
                dout      <= 1'b0;       // Right channel stays silent
            end else if (bclk_fall) begin
                if (bits_left != '0) begin
                    dout      <= shift_reg[`CODEC_WIDTH-1];  // MSB first
                    shift_reg <= shift_reg << 1;
                    bits_left <= bits_left - 1'b1;
                end else begin
                    dout <= 1'b0;        // Pad after the last bit
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tone_generator.sv
`default_nettype none

`include "music_macros.svh"

module tone_generator
    import audio_types_pkg::*;
(
    input  logic    clk_100,
    input  logic    reset,
    input  logic    new_frame,
    input  logic    playing,
    input  note_t   note,
    output sample_t sample,
    output logic    new_sample
);

    note_t frame_cnt;  // Frames into the half period
    note_t note_q;     // For note change detect
    logic  level_pos;  // Square wave currently high

    always_ff @(posedge clk_100) begin
        if (reset) begin
            frame_cnt  <= '0;
            note_q     <= '0;
            level_pos  <= 1'b1;
            sample     <= '0;
            new_sample <= 1'b0;
        end else begin
            new_sample <= new_frame;  // Sample valid one cycle after the frame
            note_q     <= note;

            if (!playing) begin
                // Paused, silence and restart high
                frame_cnt <= '0;
                level_pos <= 1'b1;
                sample    <= '0;
            end else if (note != note_q) begin
                frame_cnt <= '0;      // New pitch starts a fresh half period
                level_pos <= 1'b1;
            end else if (new_frame) begin
                if (note == '0)
                    sample <= '0;     // Rest
                else
                    sample <= level_pos ? `AMPLITUDE : -`AMPLITUDE;

                // Half period is note+1 frames
                if (frame_cnt == note) begin
                    frame_cnt <= '0;
                    level_pos <= ~level_pos;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/song_sequencer.sv
`default_nettype none

`include "music_macros.svh"

module song_sequencer
    import audio_types_pkg::*;
    import control_types_pkg::*;
#(
    parameter int BEAT_COUNT = `BEAT_COUNT
) (
    input  logic        clk_100,
    input  logic        reset,
    input  player_cmd_t cmd,
    input  logic        new_frame,
    output note_t       note,
    output logic        playing
);

    localparam int BEAT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    // Melody, one note per step
    localparam note_t SONG_TABLE [`SONG_LENGTH] = '{
        4'd3, 4'd5, 4'd1, 4'd7, 4'd2, 4'd6, 4'd4, 4'd8
    };

    step_t             step;      // Current song position
    logic [BEAT_W-1:0] beat_cnt;  // Frames into the current step
    logic              step_cmd;  // Any command that moves the step
    logic              beat_done;

    // Position plus n, wrapped at the song end
    function automatic step_t step_add(step_t s, int unsigned n);
        int unsigned sum;
        sum = int'(s) + n;
        return step_t'(sum % `SONG_LENGTH);
    endfunction

    assign step_cmd  = cmd.step_next | cmd.step_ffwd | cmd.step_rewind;
    assign beat_done = (beat_cnt == BEAT_W'(BEAT_COUNT - 1));

    always_ff @(posedge clk_100) begin
        if (reset) begin
            playing  <= 1'b0;
            step     <= '0;
            beat_cnt <= '0;
        end else begin
            if (cmd.toggle_play)
                playing <= ~playing;

            // Commands win over the beat
            if (step_cmd) begin
                beat_cnt <= '0;
                if (cmd.step_rewind)
                    step <= '0;
                else if (cmd.step_ffwd)
                    step <= step_add(step, 2);
                else
                    step <= step_add(step, 1);
            end else if (playing && new_frame) begin
                if (beat_done) begin
                    beat_cnt <= '0;
                    step     <= step_add(step, 1);  // Next note of the song
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // Table lookup, one cycle behind the step
    always_ff @(posedge clk_100) begin
        if (reset)
            note <= '0;
        else
            note <= SONG_TABLE[step];
    end

endmodule

`default_nettype wire

// File: source/mode_selector.sv
`default_nettype none

module mode_selector
    import control_types_pkg::*;
(
    input  logic         clk_100,
    input  logic         reset,
    input  logic         control_press,
    input  logic         action_press,
    output player_cmd_t  cmd,
    output player_mode_t mode
);

    player_mode_t mode_next;
    player_cmd_t  cmd_next;

    // PLAY -> NEXT -> REWIND -> FFWD -> PLAY
    always_comb begin
        unique case (mode)
            MODE_PLAY:   mode_next = MODE_NEXT;
            MODE_NEXT:   mode_next = MODE_REWIND;
            MODE_REWIND: mode_next = MODE_FFWD;
            MODE_FFWD:   mode_next = MODE_PLAY;
            default:     mode_next = MODE_PLAY;
        endcase
    end

    // Strobe belonging to the mode held before this cycle
    always_comb begin
        cmd_next = CMD_IDLE;
        if (action_press) begin
            unique case (mode)
                MODE_PLAY:   cmd_next.toggle_play = 1'b1;
                MODE_NEXT:   cmd_next.step_next   = 1'b1;
                MODE_REWIND: cmd_next.step_rewind = 1'b1;
                MODE_FFWD:   cmd_next.step_ffwd   = 1'b1;
                default:     cmd_next = CMD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        if (reset) begin
            mode <= MODE_PLAY;
            cmd  <= CMD_IDLE;
        end else begin
            cmd <= cmd_next;  // One cycle after the action press
            if (control_press)
                mode <= mode_next;
        end
    end

endmodule

`default_nettype wire

// File: source/button_press_unit.sv
`default_nettype none

`include "music_macros.svh"

module button_press_unit #(
    parameter int WIDTH = `BPU_WIDTH
) (
    input  logic clk_100,
    input  logic reset,
    input  logic in,
    output logic out
);

    logic [1:0]       sync_q;       // Two-flop synchronizer
    logic             level_q;      // Last synchronized level
    logic [WIDTH-1:0] stable_cnt;   // Cycles the level has held
    logic             debounced;    // Accepted button level
    logic             debounced_q;  // For edge detect

    always_ff @(posedge clk_100) begin
        if (reset) begin
            sync_q      <= '0;
            level_q     <= 1'b0;
            stable_cnt  <= '0;
            debounced   <= 1'b0;
            debounced_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], in};
            level_q <= sync_q[1];

            // Any change restarts the stability window
            if (sync_q[1] != level_q)
                stable_cnt <= '0;
            else if (stable_cnt != '1)
                stable_cnt <= stable_cnt + 1'b1;  // Saturate at full

            // Level accepted only once the window is full
            if (stable_cnt == '1)
                debounced <= level_q;

            debounced_q <= debounced;
        end
    end

    // Single strobe on press, nothing on release
    assign out = debounced & ~debounced_q;

endmodule

`default_nettype wire

// File: source/control_types_pkg.sv
`default_nettype none

package control_types_pkg;

    // Mode picked by the control button, in stepping order
    typedef enum logic [1:0] {
        MODE_PLAY   = 2'd0,
        MODE_NEXT   = 2'd1,
        MODE_REWIND = 2'd2,
        MODE_FFWD   = 2'd3
    } player_mode_t;

    // One-cycle command strobes, one hot or idle
    typedef struct packed {
        logic toggle_play;  // Play/pause
        logic step_next;    // Step + 1
        logic step_rewind;  // Back to step 0
        logic step_ffwd;    // Step + 2
    } player_cmd_t;

    localparam player_cmd_t CMD_IDLE = '0;  // No strobe raised

endpackage

`default_nettype wire

// File: source/audio_types_pkg.sv
`default_nettype none

`include "music_macros.svh"

package audio_types_pkg;

    localparam int SAMPLE_W = 16;   // Bits of PCM per sample

    typedef logic signed [SAMPLE_W-1:0] sample_t;            // Signed PCM sample
    typedef logic [`CODEC_WIDTH-1:0] codec_word_t;           // One I2S channel slot
    typedef logic [3:0] note_t;                              // 1..8, zero is silence
    typedef logic [$clog2(`SONG_LENGTH)-1:0] step_t;         // Position in the song

    // Sample left-aligned in the codec slot, low bits zero
    function automatic codec_word_t to_codec_word(sample_t s);
        return {s, {(`CODEC_WIDTH - SAMPLE_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// File: include/music_macros.svh
`ifndef MUSIC_MACROS_SVH
`define MUSIC_MACROS_SVH

// Debounce counter width, 2^WIDTH stable cycles per press
`define BPU_WIDTH 20

// Audio frames per song step
`define BEAT_COUNT 1000

// Steps in one song
`define SONG_LENGTH 8

// Peak level of the square wave, a quarter of full scale
`define AMPLITUDE 16'sd8192

// Slot width of one I2S channel
`define CODEC_WIDTH 24

`endif
